// File: hdl/l1_mem_pkg.sv
package l1_mem_pkg;

   localparam int ADDR_WIDTH = 32;
   localparam int OPCODE_WIDTH = 4;
   localparam int LG_CL_BYTES = 4; // 16 byte lines
   localparam int CL_BITS = (1 << LG_CL_BYTES) * 8;

   // miss queue depth
   localparam int LG_MQ_ENTRIES = 2;
   localparam int MQ_ENTRIES = 1 << LG_MQ_ENTRIES;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [CL_BITS-1:0] line_t;
   typedef logic [OPCODE_WIDTH-1:0] mem_opcode_t;
   typedef logic [LG_MQ_ENTRIES:0] mq_ptr_t; // index plus wrap bit

   localparam mem_opcode_t MEM_LD_L1D = 4'd4; // line fill
   localparam mem_opcode_t MEM_ST_L1D = 4'd7; // line write back

   typedef enum logic [1:0]
   {
      ARB_IDLE = 2'd0,
      ARB_GNT_L1D = 2'd1,
      ARB_GNT_L1I = 2'd2
   } arb_state_t;

   // wait states are named by the completion still missing
   typedef enum logic [1:0]
   {
      FLUSH_IDLE = 2'd0,
      FLUSH_WAIT_BOTH = 2'd1,
      FLUSH_WAIT_L1I = 2'd2,
      FLUSH_WAIT_L1D = 2'd3
   } flush_state_t;

endpackage

// File: hdl/mem_req_if.sv
// one request stream toward the memory arbiter
interface mem_req_if;
   import l1_mem_pkg::*;

   logic valid;
   logic ready;
   addr_t addr;
   mem_opcode_t opcode;

   // requester side
   modport src
   (
      output valid,
      output addr,
      output opcode,
      input ready
   );

   // arbiter side
   modport dst
   (
      input valid,
      input addr,
      input opcode,
      output ready
   );

endinterface

// File: hdl/l1_miss_queue.sv
module l1_miss_queue
(
   input logic clk,
   input logic reset,
   input logic in_valid,
   output logic in_ready,
   input l1_mem_pkg::addr_t in_addr,
   input l1_mem_pkg::mem_opcode_t in_opcode,
   input l1_mem_pkg::line_t in_data,
   mem_req_if.src head,
   output l1_mem_pkg::line_t head_data
);
   import l1_mem_pkg::*;

   addr_t r_addr[MQ_ENTRIES];
   mem_opcode_t r_opcode[MQ_ENTRIES];
   line_t r_data[MQ_ENTRIES];

   mq_ptr_t r_rd_ptr, n_rd_ptr;
   mq_ptr_t r_wr_ptr, n_wr_ptr;
   logic [LG_MQ_ENTRIES-1:0] rd_idx;
   logic [LG_MQ_ENTRIES-1:0] wr_idx;
   logic mq_empty;
   logic mq_full;
   logic push;
   logic pop;

   assign rd_idx = r_rd_ptr[LG_MQ_ENTRIES-1:0];
   assign wr_idx = r_wr_ptr[LG_MQ_ENTRIES-1:0];

   assign mq_empty = (r_rd_ptr == r_wr_ptr);
   // same slot, different lap
   assign mq_full = (rd_idx == wr_idx) &&
                    (r_rd_ptr[LG_MQ_ENTRIES] != r_wr_ptr[LG_MQ_ENTRIES]);

   assign in_ready = !mq_full;
   assign push = in_valid && in_ready;

   assign head.valid = !mq_empty;
   assign head.addr = r_addr[rd_idx];
   assign head.opcode = r_opcode[rd_idx];
   assign head_data = r_data[rd_idx];
   assign pop = head.valid && head.ready;

   always_comb
   begin
      n_rd_ptr = r_rd_ptr;
      n_wr_ptr = r_wr_ptr;
      if (pop)
      begin
         n_rd_ptr = r_rd_ptr + 3'd1;
      end
      if (push)
      begin
         n_wr_ptr = r_wr_ptr + 3'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         r_addr[wr_idx] <= in_addr;
         r_opcode[wr_idx] <= in_opcode;
         r_data[wr_idx] <= in_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_rd_ptr <= '0;
         r_wr_ptr <= '0;
      end
      else
      begin
         r_rd_ptr <= n_rd_ptr;
         r_wr_ptr <= n_wr_ptr;
      end
   end

endmodule

// File: hdl/mem_arbiter.sv
module mem_arbiter
(
   input logic clk,
   input logic reset,
   mem_req_if.dst l1d,
   input l1_mem_pkg::line_t l1d_data,
   mem_req_if.dst l1i,
   output logic mem_req_valid,
   output l1_mem_pkg::addr_t mem_req_addr,
   output l1_mem_pkg::mem_opcode_t mem_req_opcode,
   output l1_mem_pkg::line_t mem_req_store_data,
   input logic mem_rsp_valid,
   input l1_mem_pkg::line_t mem_rsp_load_data,
   output logic l1d_rsp_valid,
   output logic l1i_rsp_valid,
   output l1_mem_pkg::line_t rsp_data
);
   import l1_mem_pkg::*;

   arb_state_t r_state, n_state;
   logic r_last_i, n_last_i; // 1 when the l1i side won the last grant

   // pending slots, one per side
   logic r_d_valid;
   addr_t r_d_addr;
   mem_opcode_t r_d_opcode;
   line_t r_d_data;
   logic r_i_valid;
   addr_t r_i_addr;
   mem_opcode_t r_i_opcode;

   logic d_accept;
   logic i_accept;

   assign l1d_rsp_valid = (r_state == ARB_GNT_L1D) && mem_rsp_valid;
   assign l1i_rsp_valid = (r_state == ARB_GNT_L1I) && mem_rsp_valid;
   assign rsp_data = mem_rsp_load_data;

   // a slot may refill in the cycle its response arrives
   assign l1d.ready = !r_d_valid || l1d_rsp_valid;
   assign l1i.ready = !r_i_valid || l1i_rsp_valid;
   assign d_accept = l1d.valid && l1d.ready;
   assign i_accept = l1i.valid && l1i.ready;

   assign mem_req_valid = (r_state != ARB_IDLE);
   assign mem_req_addr = (r_state == ARB_GNT_L1I) ? r_i_addr : r_d_addr;
   assign mem_req_opcode = (r_state == ARB_GNT_L1I) ? r_i_opcode : r_d_opcode;
   assign mem_req_store_data = r_d_data; // loads ignore it

   always_comb
   begin
      n_state = r_state;
      n_last_i = r_last_i;
      case (r_state)
         ARB_IDLE:
         begin
            if (r_d_valid && r_i_valid)
            begin
               // tie goes to the side not served last
               n_state = r_last_i ? ARB_GNT_L1D : ARB_GNT_L1I;
               n_last_i = !r_last_i;
            end
            else if (r_d_valid)
            begin
               n_state = ARB_GNT_L1D;
               n_last_i = 1'b0;
            end
            else if (r_i_valid)
            begin
               n_state = ARB_GNT_L1I;
               n_last_i = 1'b1;
            end
         end
         ARB_GNT_L1D, ARB_GNT_L1I:
         begin
            if (mem_rsp_valid)
            begin
               n_state = ARB_IDLE;
            end
         end
         default:
         begin
            n_state = ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= ARB_IDLE;
         r_last_i <= 1'b0;
         r_d_valid <= 1'b0;
         r_i_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_last_i <= n_last_i;
         if (d_accept)
         begin
            r_d_valid <= 1'b1;
         end
         else if (l1d_rsp_valid)
         begin
            r_d_valid <= 1'b0;
         end
         if (i_accept)
         begin
            r_i_valid <= 1'b1;
         end
         else if (l1i_rsp_valid)
         begin
            r_i_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (d_accept)
      begin
         r_d_addr <= l1d.addr;
         r_d_opcode <= l1d.opcode;
         r_d_data <= l1d_data;
      end
      if (i_accept)
      begin
         r_i_addr <= l1i.addr;
         r_i_opcode <= l1i.opcode;
      end
   end

endmodule

// File: hdl/flush_tracker.sv
module flush_tracker
(
   input logic clk,
   input logic reset,
   input logic flush_req_l1d,
   input logic flush_req_l1i,
   input logic l1d_flush_complete,
   input logic l1i_flush_complete,
   output logic in_flush_mode
);
   import l1_mem_pkg::*;

   flush_state_t r_state, n_state;
   logic r_flush, n_flush;

   assign in_flush_mode = r_flush;

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1d && flush_req_l1i)
            begin
               n_state = FLUSH_WAIT_BOTH;
               n_flush = 1'b1;
            end
            else if (flush_req_l1d)
            begin
               n_state = FLUSH_WAIT_L1D; // l1i not asked, counts as done
               n_flush = 1'b1;
            end
            else if (flush_req_l1i)
            begin
               n_state = FLUSH_WAIT_L1I;
               n_flush = 1'b1;
            end
         end
         FLUSH_WAIT_BOTH:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
            else if (l1d_flush_complete)
            begin
               n_state = FLUSH_WAIT_L1I;
            end
            else if (l1i_flush_complete)
            begin
               n_state = FLUSH_WAIT_L1D;
            end
         end
         FLUSH_WAIT_L1I:
         begin
            if (l1i_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         FLUSH_WAIT_L1D:
         begin
            if (l1d_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
         begin
            n_state = FLUSH_IDLE;
            n_flush = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_flush <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
      end
   end

endmodule

// File: hdl/l1_mem_subsystem.sv
module l1_mem_subsystem
(
   input logic clk,
   input logic reset,

   // data side miss requests
   input logic l1d_req_valid,
   output logic l1d_req_ready,
   input l1_mem_pkg::addr_t l1d_req_addr,
   input l1_mem_pkg::mem_opcode_t l1d_req_opcode,
   input l1_mem_pkg::line_t l1d_req_data,

   // instruction side fills
   input logic l1i_req_valid,
   output logic l1i_req_ready,
   input l1_mem_pkg::addr_t l1i_req_addr,
   input l1_mem_pkg::mem_opcode_t l1i_req_opcode,

   // next level memory
   output logic mem_req_valid,
   output l1_mem_pkg::addr_t mem_req_addr,
   output l1_mem_pkg::mem_opcode_t mem_req_opcode,
   output l1_mem_pkg::line_t mem_req_store_data,
   input logic mem_rsp_valid,
   input l1_mem_pkg::line_t mem_rsp_load_data,

   // responses back to the caches
   output logic l1d_rsp_valid,
   output logic l1i_rsp_valid,
   output l1_mem_pkg::line_t rsp_data,

   input logic flush_req_l1d,
   input logic flush_req_l1i,
   input logic l1d_flush_complete,
   input logic l1i_flush_complete,
   output logic in_flush_mode
);
   import l1_mem_pkg::*;

   line_t mq_head_data;

   mem_req_if mq_req();
   mem_req_if i_req();

   // top ports stand in for the l1i requester
   assign i_req.valid = l1i_req_valid;
   assign i_req.addr = l1i_req_addr;
   assign i_req.opcode = l1i_req_opcode;
   assign l1i_req_ready = i_req.ready;

   l1_miss_queue i_l1_miss_queue
   (
      .clk(clk),
      .reset(reset),
      .in_valid(l1d_req_valid),
      .in_ready(l1d_req_ready),
      .in_addr(l1d_req_addr),
      .in_opcode(l1d_req_opcode),
      .in_data(l1d_req_data),
      .head(mq_req.src),
      .head_data(mq_head_data)
   );

   mem_arbiter i_mem_arbiter
   (
      .clk(clk),
      .reset(reset),
      .l1d(mq_req.dst),
      .l1d_data(mq_head_data),
      .l1i(i_req.dst),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_req_opcode(mem_req_opcode),
      .mem_req_store_data(mem_req_store_data),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data),
      .l1d_rsp_valid(l1d_rsp_valid),
      .l1i_rsp_valid(l1i_rsp_valid),
      .rsp_data(rsp_data)
   );

   // flush tracking is separate from the request path
   flush_tracker i_flush_tracker
   (
      .clk(clk),
      .reset(reset),
      .flush_req_l1d(flush_req_l1d),
      .flush_req_l1i(flush_req_l1i),
      .l1d_flush_complete(l1d_flush_complete),
      .l1i_flush_complete(l1i_flush_complete),
      .in_flush_mode(in_flush_mode)
   );

endmodule

// File: tests/l1_mem_checker.sv
module l1_mem_checker
(
   input logic clk,
   input logic reset,
   input logic l1d_req_valid,
   input logic l1d_req_ready,
   input l1_mem_pkg::addr_t l1d_req_addr,
   input l1_mem_pkg::mem_opcode_t l1d_req_opcode,
   input l1_mem_pkg::line_t l1d_req_data,
   input logic l1i_req_valid,
   input logic l1i_req_ready,
   input l1_mem_pkg::addr_t l1i_req_addr,
   input l1_mem_pkg::mem_opcode_t l1i_req_opcode,
   input logic mem_req_valid,
   input l1_mem_pkg::addr_t mem_req_addr,
   input l1_mem_pkg::mem_opcode_t mem_req_opcode,
   input l1_mem_pkg::line_t mem_req_store_data,
   input logic mem_rsp_valid,
   input logic l1d_rsp_valid,
   input logic l1i_rsp_valid,
   input l1_mem_pkg::line_t rsp_data,
   input logic flush_req_l1d,
   input logic flush_req_l1i,
   input logic l1d_flush_complete,
   input logic l1i_flush_complete,
   input logic in_flush_mode,
   output int errors,
   output int checks,
   output logic idle
);
   import l1_mem_pkg::*;

   logic [163:0] d_q[$]; // packed as opcode addr line
   int d_t[$]; // cycle of acceptance
   logic [35:0] i_q[$];
   int i_t[$];
   logic [163:0] d_head;
   logic [35:0] i_head;
   logic [163:0] cur; // fields of the outstanding memory request
   logic busy;
   logic cur_i;
   logic last_i;
   logic rsp_prev;
   logic tie;
   logic i_full;
   logic fl_mode;
   logic fl_d;
   logic fl_i;
   int cyc;
   int unserved;
   int n_err = 0;
   int n_chk = 0;

   assign errors = n_err;
   assign checks = n_chk;

   function automatic line_t expected_fill(input addr_t a);
      line_t l;
      for (int w = 0; w < 4; w++)
         l[32*w +: 32] = a ^ w;
      return l;
   endfunction

   task automatic compare_val(input string name, input line_t exp, input line_t got);
      n_chk++;
      if (exp !== got)
      begin
         n_err++;
         $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic got);
      compare_val(name, line_t'(exp), line_t'(got));
   endtask

   task automatic report_error(input string msg);
      n_err++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic check_grant();
      // both slots were full in the idle cycle that decided
      tie = (d_q.size() > 0) && (i_q.size() > 0) && (d_t[0] <= cyc - 3) &&
            (i_t[0] <= cyc - 2);
      cur_i = mem_req_addr[31]; // l1i addresses sit in the upper half
      n_chk++;
      if (tie && cur_i == last_i)
         report_error("tie granted to the side that was served last");
      if (cur_i && i_q.size() > 0)
      begin
         i_head = i_q.pop_front();
         i_t.delete(0);
         compare_val("mem_req_addr", line_t'(i_head[31:0]), line_t'(mem_req_addr));
         compare_val("mem_req_opcode", line_t'(i_head[35:32]), line_t'(mem_req_opcode));
      end
      else if (!cur_i && d_q.size() > 0)
      begin
         d_head = d_q.pop_front();
         d_t.delete(0);
         compare_val("mem_req_addr", line_t'(d_head[159:128]), line_t'(mem_req_addr));
         compare_val("mem_req_opcode", line_t'(d_head[163:160]), line_t'(mem_req_opcode));
         compare_val("mem_req_store_data", d_head[127:0], mem_req_store_data);
      end
      else
         report_error("memory request issued with nothing pending on that side");
      cur = {mem_req_opcode, mem_req_addr, mem_req_store_data};
      last_i = cur_i;
      busy = 1'b1;
   endtask

   always @(negedge clk)
   begin
      if (reset)
      begin
         compare_bit("mem_req_valid", 1'b0, mem_req_valid);
         compare_bit("in_flush_mode", 1'b0, in_flush_mode);
         compare_bit("l1d_req_ready", 1'b1, l1d_req_ready);
         compare_bit("l1i_req_ready", 1'b1, l1i_req_ready);
         d_q.delete();
         d_t.delete();
         i_q.delete();
         i_t.delete();
         busy = 1'b0;
         cur_i = 1'b0;
         last_i = 1'b0; // first tie goes to l1i
         rsp_prev = 1'b0;
         fl_mode = 1'b0;
         fl_d = 1'b0;
         fl_i = 1'b0;
         cyc = 0;
      end
      else
      begin
         cyc++;
         unserved = d_q.size() + ((busy && !cur_i) ? 1 : 0);
         if (!l1d_req_ready && unserved < 4)
            report_error("l1d_req_ready low with fewer than four data requests unserved");
         if (unserved > 5)
            report_error("more than five data requests unserved");

         // l1i slot holds a waiting or outstanding request
         i_full = (i_q.size() > 0) || (busy && cur_i);
         compare_bit("l1i_req_ready", !i_full || (mem_rsp_valid && busy && cur_i),
                     l1i_req_ready);

         if (rsp_prev)
            compare_bit("mem_req_valid", 1'b0, mem_req_valid); // drops the edge after
         else if (busy)
         begin
            compare_bit("mem_req_valid", 1'b1, mem_req_valid);
            compare_val("mem_req_addr", line_t'(cur[159:128]), line_t'(mem_req_addr));
            compare_val("mem_req_opcode", line_t'(cur[163:160]), line_t'(mem_req_opcode));
            if (!cur_i)
               compare_val("mem_req_store_data", cur[127:0], mem_req_store_data);
         end
         else if (mem_req_valid)
            check_grant();

         if (mem_rsp_valid)
         begin
            if (!busy)
               report_error("memory response with no request outstanding");
            compare_bit("l1d_rsp_valid", !cur_i, l1d_rsp_valid);
            compare_bit("l1i_rsp_valid", cur_i, l1i_rsp_valid);
            compare_val("rsp_data", expected_fill(cur[159:128]), rsp_data);
            busy = 1'b0;
         end
         else
         begin
            compare_bit("l1d_rsp_valid", 1'b0, l1d_rsp_valid);
            compare_bit("l1i_rsp_valid", 1'b0, l1i_rsp_valid);
         end
         rsp_prev = mem_rsp_valid;

         if (l1d_req_valid && l1d_req_ready)
         begin
            d_q.push_back({l1d_req_opcode, l1d_req_addr, l1d_req_data});
            d_t.push_back(cyc);
         end
         if (l1i_req_valid && l1i_req_ready)
         begin
            i_q.push_back({l1i_req_opcode, l1i_req_addr});
            i_t.push_back(cyc);
         end

         // flush model keeps the completions still owed
         compare_bit("in_flush_mode", fl_mode, in_flush_mode);
         if (!fl_mode)
         begin
            fl_d = flush_req_l1d;
            fl_i = flush_req_l1i;
         end
         else
         begin
            fl_d = fl_d && !l1d_flush_complete;
            fl_i = fl_i && !l1i_flush_complete;
         end
         fl_mode = fl_d || fl_i;
      end
      idle = !busy && (d_q.size() == 0) && (i_q.size() == 0);
   end

endmodule

// File: tests/tb_l1_mem_subsystem.sv
module tb_l1_mem_subsystem;
   import l1_mem_pkg::*;

   logic clk = 1'b0;
   logic reset;
   logic l1d_req_valid;
   logic l1d_req_ready;
   addr_t l1d_req_addr;
   mem_opcode_t l1d_req_opcode;
   line_t l1d_req_data;
   logic l1i_req_valid;
   logic l1i_req_ready;
   addr_t l1i_req_addr;
   mem_opcode_t l1i_req_opcode;
   logic mem_req_valid;
   addr_t mem_req_addr;
   mem_opcode_t mem_req_opcode;
   line_t mem_req_store_data;
   logic mem_rsp_valid;
   line_t mem_rsp_load_data;
   logic l1d_rsp_valid;
   logic l1i_rsp_valid;
   line_t rsp_data;
   logic flush_req_l1d;
   logic flush_req_l1i;
   logic l1d_flush_complete;
   logic l1i_flush_complete;
   logic in_flush_mode;

   int errors;
   int checks;
   logic idle;
   int timeouts;
   int wait_left; // memory latency countdown or -1 when none running

   l1_mem_subsystem i_l1_mem_subsystem (.*);
   l1_mem_checker i_l1_mem_checker (.*);

   initial
   begin
      forever
      begin
         #2 clk = ~clk;
      end
   end

   function automatic line_t fill_line(input addr_t a);
      line_t l;
      for (int w = 0; w < 4; w++)
         l[32*w +: 32] = a ^ w; // word index folded into the address
      return l;
   endfunction

   function automatic logic work_left();
      return l1d_req_valid || l1i_req_valid || !idle || in_flush_mode;
   endfunction

   // one clock of stimulus with handshakes sampled mid cycle
   task automatic step(input int d_pct, input int i_pct, input int fl_pct);
      logic d_fire;
      logic i_fire;
      logic req_seen;
      addr_t req_addr;
      @(negedge clk);
      d_fire = l1d_req_valid && l1d_req_ready;
      i_fire = l1i_req_valid && l1i_req_ready;
      req_seen = mem_req_valid && !mem_rsp_valid;
      req_addr = mem_req_addr;
      @(posedge clk);
      #1;
      if (!l1d_req_valid || d_fire)
      begin
         l1d_req_valid = ($urandom_range(99) < d_pct);
         l1d_req_addr = $urandom & 32'h7fff_fff0;
         l1d_req_opcode = ($urandom_range(1) == 1) ? MEM_ST_L1D : MEM_LD_L1D;
         l1d_req_data = {$urandom, $urandom, $urandom, $urandom};
      end
      if (!l1i_req_valid || i_fire)
      begin
         l1i_req_valid = ($urandom_range(99) < i_pct);
         l1i_req_addr = ($urandom & 32'h7fff_fff0) | 32'h8000_0000;
         l1i_req_opcode = MEM_LD_L1D;
      end
      flush_req_l1d = ($urandom_range(99) < fl_pct);
      flush_req_l1i = ($urandom_range(99) < fl_pct);
      l1d_flush_complete = ($urandom_range(99) < 10);
      l1i_flush_complete = ($urandom_range(99) < 10);
      mem_rsp_valid = 1'b0;
      if (req_seen)
      begin
         if (wait_left < 0)
            wait_left = $urandom_range(6, 1);
         wait_left--;
         if (wait_left == 0)
         begin
            mem_rsp_valid = 1'b1;
            mem_rsp_load_data = fill_line(req_addr);
            wait_left = -1;
         end
      end
   endtask

   task automatic run_test(input string name, input int cycles, input int d_pct,
                           input int i_pct, input int fl_pct);
      int start_errors;
      int n;
      start_errors = errors;
      repeat (cycles)
         step(d_pct, i_pct, fl_pct);
      // no new requests while the queue and the memory drain
      n = 0;
      while (work_left() && n < 200)
      begin
         step(0, 0, 0);
         n++;
      end
      if (work_left())
      begin
         $display("test %s: requests still pending after 200 drain cycles", name);
         timeouts++;
      end
      $display("test %s done: %0d errors", name, errors - start_errors);
   endtask

   initial
   begin
      void'($urandom(32'hcafe_e827));
      reset = 1'b1;
      l1d_req_valid = 1'b0;
      l1d_req_addr = '0;
      l1d_req_opcode = '0;
      l1d_req_data = '0;
      l1i_req_valid = 1'b0;
      l1i_req_addr = '0;
      l1i_req_opcode = '0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      flush_req_l1d = 1'b0;
      flush_req_l1i = 1'b0;
      l1d_flush_complete = 1'b0;
      l1i_flush_complete = 1'b0;
      wait_left = -1;
      timeouts = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      run_test("light_traffic", 400, 20, 20, 2);
      run_test("heavy_load", 800, 90, 80, 2);
      run_test("flush_storm", 400, 40, 40, 20);
      $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: list.f
hdl/l1_mem_pkg.sv
hdl/mem_req_if.sv
hdl/l1_miss_queue.sv
hdl/mem_arbiter.sv
hdl/flush_tracker.sv
hdl/l1_mem_subsystem.sv
tests/l1_mem_checker.sv
tests/tb_l1_mem_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 -f list.f --top-module tb_l1_mem_subsystem \
   -o tb_l1_mem_subsystem \
   && ./obj_dir/tb_l1_mem_subsystem | tee sim.log \
   || exit 1

grep -q "Testbench passed" sim.log && echo "simulation PASS" \
   || { echo "simulation FAIL"; exit 1; }
